// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_lcd_video, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_lcd_video -Mdir obj_dir -o tb_lcd_video
	./obj_dir/tb_lcd_video | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Finished with no errors" $(LOG) || \
		(echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+include
src/video_pkg.sv
src/bus_pkg.sv
src/video_ram.sv
src/wb_video_regs.sv
src/display_timing.sv
src/text_layer.sv
src/frame_layer.sv
src/pixel_compositor.sv
src/lcd_video_top.sv
test/tb_lcd_video.sv

// File: include/video_settings.svh
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// horizontal timing in pixel clocks
`define VIDEO_H_ACTIVE 32
`define VIDEO_H_FRONT  2
`define VIDEO_H_SYNC   3
`define VIDEO_H_BACK   3
`define VIDEO_H_TOTAL  (`VIDEO_H_ACTIVE + `VIDEO_H_FRONT + `VIDEO_H_SYNC + `VIDEO_H_BACK)

// vertical timing in lines
`define VIDEO_V_ACTIVE 16
`define VIDEO_V_FRONT  1
`define VIDEO_V_SYNC   2
`define VIDEO_V_BACK   1
`define VIDEO_V_TOTAL  (`VIDEO_V_ACTIVE + `VIDEO_V_FRONT + `VIDEO_V_SYNC + `VIDEO_V_BACK)

// text cells and frame upscale
`define VIDEO_CELL     8
`define VIDEO_FB_SCALE 2
`define VIDEO_GLYPHS   16

// wishbone widths, word addressed
`define WB_ADR_W 12
`define WB_DAT_W 32

`endif

// File: src/bus_pkg.sv
`include "video_settings.svh"

package bus_pkg;

    typedef logic [`WB_ADR_W-1:0] wb_adr_t;
    typedef logic [`WB_DAT_W-1:0] wb_dat_t;

    // control registers
    localparam wb_adr_t REG_CONTROL  = 'h000;
    localparam wb_adr_t REG_FG_COLOR = 'h001;
    localparam wb_adr_t REG_BG_COLOR = 'h002;

    // memory regions, each aligned to its own size
    localparam wb_adr_t FONT_BASE  = 'h100;
    localparam wb_adr_t CELL_BASE  = 'h200;
    localparam wb_adr_t FRAME_BASE = 'h400;

    localparam int CTRL_LAYER_BIT = 0;

    // values after reset: text layer, white on black
    localparam logic        RST_LAYER    = 1'b0;
    localparam logic [15:0] RST_FG_COLOR = 16'hFFFF;
    localparam logic [15:0] RST_BG_COLOR = 16'h0000;

    // true when adr falls in the region starting at base with 2**span_w words
    function automatic logic in_region(wb_adr_t adr, wb_adr_t base, int span_w);
        return (adr >> span_w) == (base >> span_w);
    endfunction

endpackage

// File: src/display_timing.sv
`include "video_settings.svh"
`timescale 1ns/1ps

module display_timing
    import video_pkg::*;
(
    input  logic     clk,
    input  logic     ext_reset,
    output coord_x_t x,
    output coord_y_t y,
    output logic     active,
    output logic     hsync,
    output logic     vsync
);

    localparam int HS_START = `VIDEO_H_ACTIVE + `VIDEO_H_FRONT;
    localparam int HS_END   = HS_START + `VIDEO_H_SYNC;
    localparam int VS_START = `VIDEO_V_ACTIVE + `VIDEO_V_FRONT;
    localparam int VS_END   = VS_START + `VIDEO_V_SYNC;

    coord_x_t x_next;
    coord_y_t y_next;

    always_comb begin
        x_next = x + 1'b1;
        y_next = y;
        if (x == coord_x_t'(`VIDEO_H_TOTAL - 1)) begin
            x_next = '0;
            y_next = (y == coord_y_t'(`VIDEO_V_TOTAL - 1)) ? '0 : y + 1'b1;
        end
    end

    // flags are computed from the next count so they line up with x and y
    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            // park on the last blank position so the first frame starts at 0,0
            x      <= coord_x_t'(`VIDEO_H_TOTAL - 1);
            y      <= coord_y_t'(`VIDEO_V_TOTAL - 1);
            active <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else begin
            x      <= x_next;
            y      <= y_next;
            active <= (x_next < `VIDEO_H_ACTIVE) && (y_next < `VIDEO_V_ACTIVE);
            hsync  <= (x_next >= HS_START) && (x_next < HS_END);
            vsync  <= (y_next >= VS_START) && (y_next < VS_END);
        end
    end

    assert property (@(posedge clk) disable iff (!ext_reset)
        x < `VIDEO_H_TOTAL);

endmodule

// File: src/frame_layer.sv
`include "video_settings.svh"
`timescale 1ns/1ps

module frame_layer
    import video_pkg::*;
(
    input  logic                clk,
    input  coord_x_t            x,
    input  coord_y_t            y,
    input  logic                frame_we,
    input  logic [FRAME_AW-1:0] frame_addr,
    input  rgb565_t             frame_data,
    output rgb565_t             pixel
);

    logic [FRAME_AW-1:0] frame_raddr;
    rgb565_t             frame_word;

    // each stored word covers a 2x2 block on screen
    assign frame_raddr = FRAME_AW'((y / `VIDEO_FB_SCALE) * FRAME_W + x / `VIDEO_FB_SCALE);

    video_ram #(
        .payload_t (rgb565_t),
        .DEPTH     (FRAME_DEPTH)
    ) u_frame_ram (
        .clk   (clk),
        .we    (frame_we),
        .waddr (frame_addr),
        .wdata (frame_data),
        .raddr (frame_raddr),
        .rdata (frame_word)
    );

    // extra stage to match the two reads of the text layer
    always_ff @(posedge clk) begin
        pixel <= frame_word;
    end

endmodule

// File: src/lcd_video_top.sv
`timescale 1ns/1ps

module lcd_video_top
    import video_pkg::*;
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       ext_reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_adr_t    wb_adr,
    input  wb_dat_t    wb_dat_w,
    output wb_dat_t    wb_dat_r,
    output logic       wb_ack,
    output logic       lcd_den,
    output logic       lcd_hsync,
    output logic       lcd_vsync,
    output logic [4:0] lcd_r,
    output logic [5:0] lcd_g,
    output logic [4:0] lcd_b
);

    logic                font_we;
    logic [FONT_AW-1:0]  font_addr;
    glyph_row_t          font_data;
    logic                cell_we;
    logic [CELL_AW-1:0]  cell_addr;
    cell_code_t          cell_data;
    logic                frame_we;
    logic [FRAME_AW-1:0] frame_addr;
    rgb565_t             frame_data;
    layer_sel_t          layer;
    rgb565_t             fg_color;
    rgb565_t             bg_color;

    coord_x_t x;
    coord_y_t y;
    logic     active;
    logic     hsync;
    logic     vsync;
    rgb565_t  text_pixel;
    rgb565_t  frame_pixel;

    wb_video_regs u_regs (
        .clk        (clk),
        .ext_reset  (ext_reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .font_we    (font_we),
        .font_addr  (font_addr),
        .font_data  (font_data),
        .cell_we    (cell_we),
        .cell_addr  (cell_addr),
        .cell_data  (cell_data),
        .frame_we   (frame_we),
        .frame_addr (frame_addr),
        .frame_data (frame_data),
        .layer      (layer),
        .fg_color   (fg_color),
        .bg_color   (bg_color)
    );

    display_timing u_timing (
        .clk       (clk),
        .ext_reset (ext_reset),
        .x         (x),
        .y         (y),
        .active    (active),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    // both layers see the same coordinates
    text_layer u_text (
        .clk       (clk),
        .x         (x),
        .y         (y),
        .font_we   (font_we),
        .font_addr (font_addr),
        .font_data (font_data),
        .cell_we   (cell_we),
        .cell_addr (cell_addr),
        .cell_data (cell_data),
        .fg_color  (fg_color),
        .bg_color  (bg_color),
        .pixel     (text_pixel)
    );

    frame_layer u_frame (
        .clk        (clk),
        .x          (x),
        .y          (y),
        .frame_we   (frame_we),
        .frame_addr (frame_addr),
        .frame_data (frame_data),
        .pixel      (frame_pixel)
    );

    pixel_compositor u_compositor (
        .clk         (clk),
        .ext_reset   (ext_reset),
        .active      (active),
        .hsync       (hsync),
        .vsync       (vsync),
        .layer       (layer),
        .text_pixel  (text_pixel),
        .frame_pixel (frame_pixel),
        .lcd_den     (lcd_den),
        .lcd_hsync   (lcd_hsync),
        .lcd_vsync   (lcd_vsync),
        .lcd_r       (lcd_r),
        .lcd_g       (lcd_g),
        .lcd_b       (lcd_b)
    );

endmodule

// File: src/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       ext_reset,
    input  logic       active,
    input  logic       hsync,
    input  logic       vsync,
    input  layer_sel_t layer,
    input  rgb565_t    text_pixel,
    input  rgb565_t    frame_pixel,
    output logic       lcd_den,
    output logic       lcd_hsync,
    output logic       lcd_vsync,
    output logic [4:0] lcd_r,
    output logic [5:0] lcd_g,
    output logic [4:0] lcd_b
);

    // two stages to match the layer latency
    logic [1:0] active_d;
    logic [1:0] hsync_d;
    logic [1:0] vsync_d;
    rgb565_t    chosen;

    assign chosen = (layer == LAYER_FRAME) ? frame_pixel : text_pixel;

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            active_d  <= '0;
            hsync_d   <= '0;
            vsync_d   <= '0;
            lcd_den   <= 1'b0;
            lcd_hsync <= 1'b0;
            lcd_vsync <= 1'b0;
            lcd_r     <= '0;
            lcd_g     <= '0;
            lcd_b     <= '0;
        end else begin
            active_d  <= {active_d[0], active};
            hsync_d   <= {hsync_d[0], hsync};
            vsync_d   <= {vsync_d[0], vsync};
            lcd_den   <= active_d[1];
            lcd_hsync <= hsync_d[1];
            lcd_vsync <= vsync_d[1];
            // black outside the active area
            lcd_r     <= active_d[1] ? chosen.r : '0;
            lcd_g     <= active_d[1] ? chosen.g : '0;
            lcd_b     <= active_d[1] ? chosen.b : '0;
        end
    end

endmodule

// File: src/text_layer.sv
`include "video_settings.svh"
`timescale 1ns/1ps

module text_layer
    import video_pkg::*;
(
    input  logic               clk,
    input  coord_x_t           x,
    input  coord_y_t           y,
    input  logic               font_we,
    input  logic [FONT_AW-1:0] font_addr,
    input  glyph_row_t         font_data,
    input  logic               cell_we,
    input  logic [CELL_AW-1:0] cell_addr,
    input  cell_code_t         cell_data,
    input  rgb565_t            fg_color,
    input  rgb565_t            bg_color,
    output rgb565_t            pixel
);

    localparam int OFS_W = $clog2(`VIDEO_CELL);

    logic [CELL_AW-1:0] cell_raddr;
    logic [FONT_AW-1:0] font_raddr;
    cell_code_t         cell_code;
    glyph_row_t         glyph_row;
    logic [OFS_W-1:0]   row_d1;
    logic [OFS_W-1:0]   col_d1;
    logic [OFS_W-1:0]   col_d2;

    // outside the active area the address wraps, those pixels are blanked later
    assign cell_raddr = CELL_AW'((y / `VIDEO_CELL) * CELL_COLS + x / `VIDEO_CELL);

    video_ram #(
        .payload_t (cell_code_t),
        .DEPTH     (CELL_DEPTH)
    ) u_cell_ram (
        .clk   (clk),
        .we    (cell_we),
        .waddr (cell_addr),
        .wdata (cell_data),
        .raddr (cell_raddr),
        .rdata (cell_code)
    );

    // offsets inside the cell follow the reads
    always_ff @(posedge clk) begin
        row_d1 <= OFS_W'(y % `VIDEO_CELL);
        col_d1 <= OFS_W'(x % `VIDEO_CELL);
        col_d2 <= col_d1;
    end

    assign font_raddr = FONT_AW'(cell_code * `VIDEO_CELL + row_d1);

    video_ram #(
        .payload_t (glyph_row_t),
        .DEPTH     (FONT_DEPTH)
    ) u_font_ram (
        .clk   (clk),
        .we    (font_we),
        .waddr (font_addr),
        .wdata (font_data),
        .raddr (font_raddr),
        .rdata (glyph_row)
    );

    assign pixel = glyph_row[`VIDEO_CELL - 1 - col_d2] ? fg_color : bg_color;

endmodule

// File: src/video_pkg.sv
`include "video_settings.svh"

package video_pkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef logic [$clog2(`VIDEO_H_TOTAL)-1:0] coord_x_t;
    typedef logic [$clog2(`VIDEO_V_TOTAL)-1:0] coord_y_t;

    typedef logic [$clog2(`VIDEO_GLYPHS)-1:0] cell_code_t;
    // bit 7 is the leftmost pixel of the row
    typedef logic [`VIDEO_CELL-1:0] glyph_row_t;

    typedef enum logic {
        LAYER_TEXT  = 1'b0,
        LAYER_FRAME = 1'b1
    } layer_sel_t;

    // memory geometry derived from the panel
    localparam int CELL_COLS   = `VIDEO_H_ACTIVE / `VIDEO_CELL;
    localparam int CELL_ROWS   = `VIDEO_V_ACTIVE / `VIDEO_CELL;
    localparam int CELL_DEPTH  = CELL_COLS * CELL_ROWS;
    localparam int FONT_DEPTH  = `VIDEO_GLYPHS * `VIDEO_CELL;
    localparam int FRAME_W     = `VIDEO_H_ACTIVE / `VIDEO_FB_SCALE;
    localparam int FRAME_H     = `VIDEO_V_ACTIVE / `VIDEO_FB_SCALE;
    localparam int FRAME_DEPTH = FRAME_W * FRAME_H;
    localparam int FONT_AW     = $clog2(FONT_DEPTH);
    localparam int CELL_AW     = $clog2(CELL_DEPTH);
    localparam int FRAME_AW    = $clog2(FRAME_DEPTH);

endpackage

// File: src/video_ram.sv
`timescale 1ns/1ps

module video_ram
    import video_pkg::*;
#(
    parameter type payload_t = rgb565_t,
    parameter int  DEPTH     = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // registered read, one cycle latency
        rdata <= mem[raddr];
    end

endmodule

// File: src/wb_video_regs.sv
`timescale 1ns/1ps

module wb_video_regs
    import video_pkg::*;
    import bus_pkg::*;
(
    input  logic                clk,
    input  logic                ext_reset,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  wb_adr_t             wb_adr,
    input  wb_dat_t             wb_dat_w,
    output wb_dat_t             wb_dat_r,
    output logic                wb_ack,
    output logic                font_we,
    output logic [FONT_AW-1:0]  font_addr,
    output glyph_row_t          font_data,
    output logic                cell_we,
    output logic [CELL_AW-1:0]  cell_addr,
    output cell_code_t          cell_data,
    output logic                frame_we,
    output logic [FRAME_AW-1:0] frame_addr,
    output rgb565_t             frame_data,
    output layer_sel_t          layer,
    output rgb565_t             fg_color,
    output rgb565_t             bg_color
);

    logic    access;
    logic    hit_font;
    logic    hit_cell;
    logic    hit_frame;
    wb_dat_t read_word;

    // a new strobe, not the cycle in which it is being acked
    assign access = wb_cyc && wb_stb && !wb_ack;

    assign hit_font  = in_region(wb_adr, FONT_BASE, FONT_AW);
    assign hit_cell  = in_region(wb_adr, CELL_BASE, CELL_AW);
    assign hit_frame = in_region(wb_adr, FRAME_BASE, FRAME_AW);

    // write pulses go straight to the memory hit
    assign font_we    = access && wb_we && hit_font;
    assign font_addr  = wb_adr[FONT_AW-1:0];
    assign font_data  = wb_dat_w[$bits(glyph_row_t)-1:0];
    assign cell_we    = access && wb_we && hit_cell;
    assign cell_addr  = wb_adr[CELL_AW-1:0];
    assign cell_data  = wb_dat_w[$bits(cell_code_t)-1:0];
    assign frame_we   = access && wb_we && hit_frame;
    assign frame_addr = wb_adr[FRAME_AW-1:0];
    assign frame_data = wb_dat_w[$bits(rgb565_t)-1:0];

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            wb_ack   <= 1'b0;
            layer    <= layer_sel_t'(RST_LAYER);
            fg_color <= RST_FG_COLOR;
            bg_color <= RST_BG_COLOR;
        end else begin
            wb_ack <= access;
            if (access && wb_we) begin
                case (wb_adr)
                    REG_CONTROL:  layer    <= layer_sel_t'(wb_dat_w[CTRL_LAYER_BIT]);
                    REG_FG_COLOR: fg_color <= wb_dat_w[$bits(rgb565_t)-1:0];
                    REG_BG_COLOR: bg_color <= wb_dat_w[$bits(rgb565_t)-1:0];
                    default: ;
                endcase
            end
        end
    end

    // memories are write only from the bus side
    always_comb begin
        case (wb_adr)
            REG_CONTROL:  read_word = wb_dat_t'(layer);
            REG_FG_COLOR: read_word = wb_dat_t'(fg_color);
            REG_BG_COLOR: read_word = wb_dat_t'(bg_color);
            default:      read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= read_word;
        end
    end

    // single cycle ack per strobe
    assert property (@(posedge clk) disable iff (!ext_reset)
        wb_ack |=> !wb_ack);

    // ack only answers a cycle in which the master strobed
    assert property (@(posedge clk) disable iff (!ext_reset)
        wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

// File: test/tb_lcd_video.sv
`include "video_settings.svh"
`timescale 1ns/1ps

module tb_lcd_video;

    localparam int CLK_PERIOD   = 100;
    localparam int FRAME_CYCLES = `VIDEO_H_TOTAL * `VIDEO_V_TOTAL;
    localparam int CELL_COLS    = `VIDEO_H_ACTIVE / `VIDEO_CELL;
    localparam int FRAME_W      = `VIDEO_H_ACTIVE / `VIDEO_FB_SCALE;
    localparam int ACK_LIMIT    = 8;
    localparam int BUS_OPS      = 300;
    // six frames plus three cycles per bus access with half again as margin
    localparam int WATCHDOG_CYCLES = (6 * FRAME_CYCLES + 3 * BUS_OPS) * 3 / 2;
    localparam int N_OPS        = 20;

    typedef struct {
        bit          is_write;
        logic [11:0] adr;
        logic [31:0] data;
        logic [31:0] expected;
    } bus_op_t;

    // register traffic where each read carries the value it must return
    bus_op_t ops [N_OPS] = '{
        '{1'b1, 12'h001, 32'h0000_1234, 32'h0},
        '{1'b0, 12'h001, 32'h0,         32'h0000_1234},
        '{1'b1, 12'h002, 32'h0000_ABCD, 32'h0},
        '{1'b0, 12'h002, 32'h0,         32'h0000_ABCD},
        '{1'b1, 12'h000, 32'h0000_0001, 32'h0},
        '{1'b0, 12'h000, 32'h0,         32'h0000_0001},
        '{1'b0, 12'h001, 32'h0,         32'h0000_1234},
        '{1'b1, 12'h001, 32'hFFFF_F800, 32'h0},
        '{1'b0, 12'h001, 32'h0,         32'h0000_F800},
        '{1'b1, 12'h000, 32'hFFFF_FFFE, 32'h0},
        '{1'b0, 12'h000, 32'h0,         32'h0},
        // memory regions never read back
        '{1'b1, 12'h105, 32'h0000_00A5, 32'h0},
        '{1'b0, 12'h105, 32'h0,         32'h0},
        '{1'b1, 12'h203, 32'h0000_0007, 32'h0},
        '{1'b0, 12'h203, 32'h0,         32'h0},
        '{1'b1, 12'h47F, 32'h0000_BEEF, 32'h0},
        '{1'b0, 12'h47F, 32'h0,         32'h0},
        '{1'b0, 12'h100, 32'h0,         32'h0},
        '{1'b0, 12'h003, 32'h0,         32'h0},
        '{1'b0, 12'h002, 32'h0,         32'h0000_ABCD}
    };

    logic        clk;
    logic        ext_reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [11:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        lcd_den;
    logic        lcd_hsync;
    logic        lcd_vsync;
    logic [4:0]  lcd_r;
    logic [5:0]  lcd_g;
    logic [4:0]  lcd_b;

    // reference model of what the bus has written
    logic [7:0]  font_m  [128];
    logic [3:0]  cell_m  [8];
    logic [15:0] frame_m [128];
    logic        layer_m;
    logic [15:0] fg_m;
    logic [15:0] bg_m;

    logic [31:0] lfsr_state = 32'h486e;
    logic [31:0] rdata;
    int          error_count = 0;
    int          check_count = 0;
    int          test_num = 0;
    int          test_first_error;
    string       test_name;

    lcd_video_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        test_first_error = error_count;
    endtask

    task automatic end_test();
        $display("test %0d %s: %s, %0d errors", test_num, test_name,
                 (error_count == test_first_error) ? "ok" : "FAILED",
                 error_count - test_first_error);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return w;
    endfunction

    task automatic model_write(input logic [11:0] adr, input logic [31:0] data);
        if (adr == 12'h000) layer_m = data[0];
        else if (adr == 12'h001) fg_m = data[15:0];
        else if (adr == 12'h002) bg_m = data[15:0];
        else if (adr >= 12'h100 && adr < 12'h180) font_m[int'(adr) - 'h100] = data[7:0];
        else if (adr >= 12'h200 && adr < 12'h208) cell_m[int'(adr) - 'h200] = data[3:0];
        else if (adr >= 12'h400 && adr < 12'h480) frame_m[int'(adr) - 'h400] = data[15:0];
    endtask

    // classic handshake followed by one idle cycle in which ack must be low again
    task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] data,
                             output logic [31:0] result);
        int waited;
        waited = 0;
        result = '0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            error_count++;
            $display("bus access to %h got no ack within %0d cycles", adr, ACK_LIMIT);
        end else begin
            result = wb_dat_r;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        check_value("wb_ack one cycle", 32'h0, wb_ack);
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
        model_write(adr, data);
    endtask

    task automatic bus_read(input logic [11:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    function automatic logic [15:0] text_expected(input int px, input int py);
        logic [3:0] code;
        logic [7:0] row;
        code = cell_m[(py / `VIDEO_CELL) * CELL_COLS + px / `VIDEO_CELL];
        row  = font_m[int'(code) * `VIDEO_CELL + py % `VIDEO_CELL];
        return row[`VIDEO_CELL - 1 - px % `VIDEO_CELL] ? fg_m : bg_m;
    endfunction

    function automatic logic [15:0] frame_expected(input int px, input int py);
        return frame_m[(py / `VIDEO_FB_SCALE) * FRAME_W + px / `VIDEO_FB_SCALE];
    endfunction

    // scans one frame from a vsync rise to the next
    task automatic scan_frame(input bit check_pixels);
        int          waited;
        int          pix;
        int          line_den;
        int          den_lines;
        int          last_hs;
        logic        found;
        logic        hs_prev;
        logic        vs_prev;
        logic [15:0] color;
        waited = 0;
        found = 1'b0;
        @(negedge clk);
        vs_prev = lcd_vsync;
        while (!found && waited < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            found = lcd_vsync && !vs_prev;
            vs_prev = lcd_vsync;
            waited++;
        end
        if (!found) begin
            error_count++;
            $display("no lcd_vsync pulse within %0d cycles", 2 * FRAME_CYCLES);
        end else begin
            pix = 0;
            line_den = 0;
            den_lines = 0;
            last_hs = -1;
            hs_prev = lcd_hsync;
            for (int k = 0; k < FRAME_CYCLES; k++) begin
                if (k > 0) begin
                    @(negedge clk);
                    if (lcd_vsync && !vs_prev) begin
                        error_count++;
                        $display("second lcd_vsync pulse %0d cycles into the frame", k);
                    end
                    vs_prev = lcd_vsync;
                end
                if (lcd_hsync && !hs_prev) begin
                    if (last_hs >= 0) check_value("lcd_hsync period", 40, k - last_hs);
                    if (line_den != 0) begin
                        check_value("lcd_den per line", `VIDEO_H_ACTIVE, line_den);
                        den_lines++;
                    end
                    line_den = 0;
                    last_hs = k;
                end
                hs_prev = lcd_hsync;
                color = {lcd_r, lcd_g, lcd_b};
                if (lcd_den) begin
                    // the expected pixel follows the layer held in the model
                    if (check_pixels) begin
                        if (layer_m) begin
                            check_value("lcd_rgb frame",
                                        frame_expected(pix % 32, pix / 32), color);
                        end else begin
                            check_value("lcd_rgb text",
                                        text_expected(pix % 32, pix / 32), color);
                        end
                    end
                    line_den++;
                    pix++;
                end else begin
                    check_value("lcd_rgb blank", 32'h0, color);
                end
            end
            check_value("lines with lcd_den", `VIDEO_V_ACTIVE, den_lines);
            check_value("lcd_den per frame", `VIDEO_H_ACTIVE * `VIDEO_V_ACTIVE, pix);
            @(negedge clk);
            check_value("lcd_vsync rise after a frame", 32'h1, lcd_vsync && !vs_prev);
        end
    endtask

    initial begin
        ext_reset = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;

        start_test("reset");
        repeat (5) @(posedge clk);
        #1;
        check_value("lcd_den", 32'h0, lcd_den);
        check_value("lcd_hsync", 32'h0, lcd_hsync);
        check_value("lcd_vsync", 32'h0, lcd_vsync);
        check_value("lcd_rgb", 32'h0, {lcd_r, lcd_g, lcd_b});
        ext_reset = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_value("wb_ack idle", 32'h0, wb_ack);
        end
        model_write(12'h000, 32'h0);
        model_write(12'h001, 32'hFFFF);
        model_write(12'h002, 32'h0);
        bus_read(12'h000, rdata);
        check_value("control", 32'h0, rdata);
        bus_read(12'h001, rdata);
        check_value("fg_color", 32'hFFFF, rdata);
        bus_read(12'h002, rdata);
        check_value("bg_color", 32'h0, rdata);
        end_test();

        start_test("panel timing");
        scan_frame(1'b0);
        end_test();

        start_test("register table");
        for (int i = 0; i < N_OPS; i++) begin
            if (ops[i].is_write) begin
                bus_write(ops[i].adr, ops[i].data);
            end else begin
                bus_read(ops[i].adr, rdata);
                check_value($sformatf("wb_dat_r from %h", ops[i].adr), ops[i].expected, rdata);
            end
        end
        end_test();

        start_test("text layer");
        bus_write(12'h000, 32'h0);
        bus_write(12'h001, 32'h0000_F81F);
        bus_write(12'h002, 32'h0000_07E0);
        for (int g = 0; g < `VIDEO_GLYPHS; g++) begin
            for (int r = 0; r < `VIDEO_CELL; r++) begin
                bus_write(12'h100 + 12'(g * 8 + r), 32'((g * 29 + r * 71) ^ 165) & 32'hFF);
            end
        end
        for (int i = 0; i < 8; i++) begin
            bus_write(12'h200 + 12'(i), 32'((i * 5 + 3) % 16));
        end
        scan_frame(1'b1);
        end_test();

        start_test("frame layer");
        for (int i = 0; i < 128; i++) begin
            bus_write(12'h400 + 12'(i), {16'h0, random_word()});
        end
        bus_write(12'h000, 32'h1);
        scan_frame(1'b1);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", test_num, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
